//--- common/genesis_bus_config.svh
// Bus decode configuration macros
// Widths of the request fields, bank register count and the byte base
// addresses of every decode region in the main-bus map
`ifndef GENESIS_BUS_CONFIG_SVH
`define GENESIS_BUS_CONFIG_SVH

// ------------------------------------------------------------
// Widths
// ------------------------------------------------------------

// Word address, bits 23 to 1 of the 68000 bus
`define GEN_ADDR_W 23
`define GEN_DATA_W 16

// Translated cartridge ROM word address
`define GEN_ROM_W 24

// SSF2 style mapper
`define GEN_BANK_COUNT 8
`define GEN_BANK_W 5

// SRAM word address, bits 16 to 1
`define GEN_SRAM_W 16

// Banking only applies to cartridges larger than this word count
`define GEN_BANK_MIN_ROMSZ 24'h200000

// ------------------------------------------------------------
// Region base addresses (byte)
// ------------------------------------------------------------

// Z80 window, also the end of cartridge space
`define GEN_ZBUS_BASE 24'hA00000
`define GEN_IO_BASE 24'hA10000
// Z80 bus request at +0x100, Z80 reset at +0x200
`define GEN_CTRL_BASE 24'hA11000
`define GEN_BANKREG_BASE 24'hA13000
`define GEN_VDP_BASE 24'hC00000
`define GEN_RAM_BASE 24'hE00000

`endif

//--- common/genesis_bus_pkg.sv
// Shared bus types
// Vector typedefs, answering region code and the request, part result
// and response structs
`include "genesis_bus_config.svh"

package genesis_bus_pkg;

	// ------------------------------------------------------------
	// Vectors
	// ------------------------------------------------------------

	// 68000 word address, bit 0 of the vector is bus bit 1
	typedef logic [`GEN_ADDR_W-1:0] bus_addr_t;

	typedef logic [`GEN_DATA_W-1:0] bus_data_t;

	// Word address into the cartridge image
	typedef logic [`GEN_ROM_W-1:0] rom_addr_t;

	typedef logic [`GEN_BANK_W-1:0] bank_t;

	typedef logic [`GEN_SRAM_W-1:0] sram_addr_t;

	// ------------------------------------------------------------
	// Region code
	// ------------------------------------------------------------

	typedef enum logic [3:0] {
		NONE    = 4'd0,
		ROM     = 4'd1,
		SRAM    = 4'd2,
		BANKREG = 4'd3,
		ZBUS    = 4'd4,
		IO      = 4'd5,
		CTRL    = 4'd6,
		VDP     = 4'd7,
		RAM     = 4'd8
	} region_e;

	// ------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------

	// One bus cycle from the 68000
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      rnw;
		// Upper byte enable in bit 1
		logic [1:0] be;
	} bus_req_t;

	// Output of one decoding part
	typedef struct packed {
		logic      hit;
		region_e   region;
		rom_addr_t rom_addr;
		bus_data_t rdata;
	} part_result_t;

	typedef struct packed {
		region_e    region;
		rom_addr_t  rom_addr;
		sram_addr_t sram_addr;
		bus_data_t  rdata;
	} bus_rsp_t;

endpackage

//--- hw/bus/cart_mapper.sv
// Cartridge space decode
// ROM with optional SSF2 bank translation, SRAM overlay at 0x200000
// and the A130xx mapper register window
`timescale 1ns/1ps
`include "genesis_bus_config.svh"

module cart_mapper (
	input  logic                          MCLK,
	input  logic                          reset,
	input  logic                          req_valid,
	input  genesis_bus_pkg::bus_req_t     req,
	input  genesis_bus_pkg::rom_addr_t    romsz,
	output logic                          cart_valid,
	output genesis_bus_pkg::part_result_t cart_res
);

	localparam int IDX_W = $clog2(`GEN_BANK_COUNT);

	logic [`GEN_ADDR_W:0]          byte_addr;
	genesis_bus_pkg::rom_addr_t    word_addr;
	logic [IDX_W-1:0]              bank_sel;
	logic [IDX_W-1:0]              reg_idx;
	logic                          in_cart;
	logic                          in_bankreg;
	logic                          bank_wr;
	genesis_bus_pkg::bank_t        bank_reg [`GEN_BANK_COUNT];
	logic                          bank_mode;
	logic                          sram_en;
	genesis_bus_pkg::part_result_t res_d;

	assign byte_addr = {req.addr, 1'b0};
	assign word_addr = {1'b0, req.addr};

	// Bank picked by bits 21:19, register index by bits 3:1
	assign bank_sel = req.addr[20:18];
	assign reg_idx = req.addr[2:0];

	assign in_cart = byte_addr < `GEN_ZBUS_BASE;
	assign in_bankreg = byte_addr[23:8] == 16'(`GEN_BANKREG_BASE >> 8);
	assign bank_wr = req_valid && in_bankreg && !req.rnw;

	// ------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------

	always_comb begin
		res_d = '0;
		res_d.region = genesis_bus_pkg::NONE;
		// SRAM offset rides along in the low bits
		res_d.rom_addr = word_addr;

		if (in_cart) begin
			if (sram_en && req.addr[22:20] == 3'd1) begin
				res_d.hit = 1'b1;
				res_d.region = genesis_bus_pkg::SRAM;
			end else if (word_addr < romsz) begin
				res_d.hit = 1'b1;
				res_d.region = genesis_bus_pkg::ROM;
				if (bank_mode) begin
					res_d.rom_addr = {1'b0, bank_reg[bank_sel], req.addr[17:0]};
				end
			end
		end else if (in_bankreg) begin
			// Registers are write only
			res_d.hit = 1'b1;
			res_d.region = genesis_bus_pkg::BANKREG;
		end
	end

	// ------------------------------------------------------------
	// Mapper registers
	// ------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			for (int i = 0; i < `GEN_BANK_COUNT; i++) begin
				bank_reg[i] <= genesis_bus_pkg::bank_t'(i);
			end
			bank_mode <= 1'b0;
			sram_en <= 1'b0;
		end else if (bank_wr) begin
			if (reg_idx == '0) begin
				sram_en <= req.wdata[0];
			end else if (romsz > `GEN_BANK_MIN_ROMSZ) begin
				bank_mode <= 1'b1;
				bank_reg[reg_idx] <= req.wdata[`GEN_BANK_W-1:0];
			end
		end
	end

	// Result stage
	always_ff @(posedge MCLK) begin
		if (reset) begin
			cart_valid <= 1'b0;
		end else begin
			cart_valid <= req_valid;
		end
	end

	always_ff @(posedge MCLK) begin
		if (req_valid) begin
			cart_res <= res_d;
		end
	end

endmodule

//--- hw/bus/sys_space_decoder.sv
// System space decode
// Z80 window, I/O, Z80 bus request and reset registers, VDP with its
// mirrors and work RAM
`timescale 1ns/1ps
`include "genesis_bus_config.svh"

module sys_space_decoder (
	input  logic                          MCLK,
	input  logic                          reset,
	input  logic                          req_valid,
	input  genesis_bus_pkg::bus_req_t     req,
	input  logic                          z80_busak,
	output logic                          sys_valid,
	output genesis_bus_pkg::part_result_t sys_res,
	output logic                          z80_busreq,
	output logic                          z80_run
);

	logic [`GEN_ADDR_W:0]          byte_addr;
	logic [3:0]                    ctrl_idx;
	logic                          in_zbus;
	logic                          in_io;
	logic                          in_ctrl_blk;
	logic                          sel_busreq;
	logic                          sel_run;
	logic                          in_vdp;
	logic                          in_ram;
	logic                          ctrl_wr;
	genesis_bus_pkg::part_result_t res_d;

	assign byte_addr = {req.addr, 1'b0};
	assign ctrl_idx = req.addr[10:7];

	assign in_zbus = byte_addr[23:16] == 8'(`GEN_ZBUS_BASE >> 16);
	assign in_io = byte_addr[23:5] == 19'(`GEN_IO_BASE >> 5);

	// Only A111xx and A112xx, low byte offset zero
	assign in_ctrl_blk = byte_addr[23:12] == 12'(`GEN_CTRL_BASE >> 12)
		&& req.addr[6:0] == '0;
	assign sel_busreq = in_ctrl_blk && ctrl_idx == 4'd1;
	assign sel_run = in_ctrl_blk && ctrl_idx == 4'd2;

	// Mirrors repeat wherever bits 18:16 and 7:5 stay clear
	assign in_vdp = byte_addr[23:21] == 3'(`GEN_VDP_BASE >> 21)
		&& byte_addr[18:16] == 3'd0
		&& byte_addr[7:5] == 3'd0;

	assign in_ram = byte_addr >= `GEN_RAM_BASE;

	assign ctrl_wr = req_valid && (sel_busreq || sel_run) && !req.rnw && req.be[1];

	// ------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------

	always_comb begin
		res_d = '0;
		res_d.region = genesis_bus_pkg::NONE;

		if (in_zbus) begin
			// 68000 owns the Z80 bus only while the Z80 is held and running
			if (z80_busreq && z80_run) begin
				res_d.hit = 1'b1;
				res_d.region = genesis_bus_pkg::ZBUS;
			end
		end else if (in_io) begin
			res_d.hit = 1'b1;
			res_d.region = genesis_bus_pkg::IO;
		end else if (sel_busreq || sel_run) begin
			res_d.hit = 1'b1;
			res_d.region = genesis_bus_pkg::CTRL;
			res_d.rdata[8] = sel_busreq ? z80_busak : z80_run;
		end else if (in_vdp) begin
			res_d.hit = 1'b1;
			res_d.region = genesis_bus_pkg::VDP;
		end else if (in_ram) begin
			res_d.hit = 1'b1;
			res_d.region = genesis_bus_pkg::RAM;
		end
	end

	// ------------------------------------------------------------
	// Z80 control registers
	// ------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq <= 1'b0;
			z80_run <= 1'b0;
		end else if (ctrl_wr) begin
			if (sel_busreq) begin
				z80_busreq <= req.wdata[8];
			end
			if (sel_run) begin
				z80_run <= req.wdata[8];
			end
		end
	end

	// Result stage
	always_ff @(posedge MCLK) begin
		if (reset) begin
			sys_valid <= 1'b0;
		end else begin
			sys_valid <= req_valid;
		end
	end

	always_ff @(posedge MCLK) begin
		if (req_valid) begin
			sys_res <= res_d;
		end
	end

endmodule

//--- hw/bus/bus_responder.sv
// Response stage
// Picks the part result that claimed the address and registers the
// combined response with its SRAM offset
`timescale 1ns/1ps
`include "genesis_bus_config.svh"

module bus_responder (
	input  logic                          MCLK,
	input  logic                          reset,
	input  logic                          cart_valid,
	input  genesis_bus_pkg::part_result_t cart_res,
	input  logic                          sys_valid,
	input  genesis_bus_pkg::part_result_t sys_res,
	output logic                          rsp_valid,
	output genesis_bus_pkg::bus_rsp_t     rsp
);

	genesis_bus_pkg::bus_rsp_t rsp_d;
	logic                      part_valid;

	// Both parts run in lockstep
	assign part_valid = cart_valid | sys_valid;

	always_comb begin
		rsp_d.region = genesis_bus_pkg::NONE;
		rsp_d.rom_addr = cart_res.rom_addr;
		rsp_d.rdata = '0;
		// Low word bits of the request, valid whenever SRAM answers
		rsp_d.sram_addr = cart_res.rom_addr[`GEN_SRAM_W-1:0];

		if (cart_res.hit) begin
			rsp_d.region = cart_res.region;
			rsp_d.rdata = cart_res.rdata;
		end else if (sys_res.hit) begin
			rsp_d.region = sys_res.region;
			rsp_d.rom_addr = sys_res.rom_addr;
			rsp_d.rdata = sys_res.rdata;
		end
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= part_valid;
		end
	end

	always_ff @(posedge MCLK) begin
		if (part_valid) begin
			rsp <= rsp_d;
		end
	end

endmodule

//--- hw/genesis_bus_top.sv
// Main bus decode pipeline
// Cartridge mapper and system decoder in parallel, then the responder
`timescale 1ns/1ps

module genesis_bus_top (
	input  logic                       MCLK,
	input  logic                       reset,
	input  logic                       req_valid,
	input  genesis_bus_pkg::bus_req_t  req,
	input  genesis_bus_pkg::rom_addr_t romsz,
	input  logic                       z80_busak,
	output logic                       rsp_valid,
	output genesis_bus_pkg::bus_rsp_t  rsp,
	output logic                       z80_busreq,
	output logic                       z80_run
);

	logic                          cart_valid;
	genesis_bus_pkg::part_result_t cart_res;
	logic                          sys_valid;
	genesis_bus_pkg::part_result_t sys_res;

	// ------------------------------------------------------------
	// Request stage
	// ------------------------------------------------------------

	cart_mapper cart_mapper_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.romsz      (romsz),
		.cart_valid (cart_valid),
		.cart_res   (cart_res)
	);

	sys_space_decoder sys_space_decoder_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.z80_busak  (z80_busak),
		.sys_valid  (sys_valid),
		.sys_res    (sys_res),
		.z80_busreq (z80_busreq),
		.z80_run    (z80_run)
	);

	// Response stage
	bus_responder bus_responder_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.cart_valid (cart_valid),
		.cart_res   (cart_res),
		.sys_valid  (sys_valid),
		.sys_res    (sys_res),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp)
	);

endmodule

//--- sim/genesis_bus_asserts.sv
// Concurrent checks on the bus decode top level
// Pipeline latency, Z80 control reset state and VDP mirror decode
`timescale 1ns/1ps
`include "genesis_bus_config.svh"

module genesis_bus_asserts (
	input logic                      MCLK,
	input logic                      reset,
	input logic                      req_valid,
	input genesis_bus_pkg::bus_req_t req,
	input logic                      rsp_valid,
	input genesis_bus_pkg::bus_rsp_t rsp,
	input logic                      z80_busreq,
	input logic                      z80_run
);

	int          assert_fails = 0;
	logic [23:0] byte_addr;
	logic        ctrl_wr;
	logic        ctrl_written;
	logic        vdp_req;

	assign byte_addr = {req.addr, 1'b0};

	// Write to A111xx or A112xx with the upper byte enabled
	assign ctrl_wr = req_valid && !req.rnw && req.be[1]
		&& byte_addr[23:12] == 12'(`GEN_CTRL_BASE >> 12) && byte_addr[7:0] == 8'h00
		&& (byte_addr[11:8] == 4'h1 || byte_addr[11:8] == 4'h2);

	assign vdp_req = req_valid && byte_addr[23:21] == 3'(`GEN_VDP_BASE >> 21)
		&& byte_addr[18:16] == 3'd0 && byte_addr[7:5] == 3'd0;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			ctrl_written <= 1'b0;
		end else if (ctrl_wr) begin
			ctrl_written <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Properties
	// ------------------------------------------------------------

	latency_chk: assert property (@(posedge MCLK) disable iff (reset)
		rsp_valid == $past(req_valid, 2))
	else begin
		$error("rsp_valid does not follow req_valid by two cycles");
		assert_fails++;
	end

	z80_idle_chk: assert property (@(posedge MCLK) disable iff (reset)
		!ctrl_written |-> !z80_busreq && !z80_run)
	else begin
		$error("Z80 control output high before any control write");
		assert_fails++;
	end

	vdp_region_chk: assert property (@(posedge MCLK) disable iff (reset)
		rsp_valid && $past(vdp_req, 2) |-> rsp.region == genesis_bus_pkg::VDP)
	else begin
		$error("VDP mirror address answered by another region");
		assert_fails++;
	end

endmodule

bind genesis_bus_top genesis_bus_asserts asserts_i (
	.MCLK       (MCLK),
	.reset      (reset),
	.req_valid  (req_valid),
	.req        (req),
	.rsp_valid  (rsp_valid),
	.rsp        (rsp),
	.z80_busreq (z80_busreq),
	.z80_run    (z80_run)
);

//--- sim/genesis_bus_tb.sv
// Testbench for the main bus decode pipeline
// Directed and random requests with expected responses from the address
// map rules, one report line per test and a closing summary
`timescale 1ns/1ps
`include "genesis_bus_config.svh"

module genesis_bus_tb;

	// Five short tests need a few hundred cycles at most
	localparam int MAX_CYCLES = 2000;
	localparam logic RD = 1'b1;
	localparam logic WR = 1'b0;

	logic                       MCLK;
	logic                       reset;
	logic                       req_valid;
	genesis_bus_pkg::bus_req_t  req;
	genesis_bus_pkg::rom_addr_t romsz;
	logic                       z80_busak;
	logic                       rsp_valid;
	genesis_bus_pkg::bus_rsp_t  rsp;
	logic                       z80_busreq;
	logic                       z80_run;

	genesis_bus_pkg::bus_rsp_t expect_q[$];
	genesis_bus_pkg::bus_rsp_t exp_rsp;
	string                     test_name;
	int                        error_count;
	int                        check_count;
	int                        pass_tests;
	int                        fail_tests;
	int                        cycle_count;
	int                        errors_before;

	genesis_bus_top dut_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.romsz      (romsz),
		.z80_busak  (z80_busak),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.z80_busreq (z80_busreq),
		.z80_run    (z80_run)
	);

	always #4 MCLK = ~MCLK;

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	function automatic int total_errors();
		return error_count + dut_i.asserts_i.assert_fails;
	endfunction

	task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		assert (act == exp)
		else begin
			$display("Fail %s %s: expected %0h, actual %0h", test_name, field, exp, act);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		@(posedge MCLK);
		reset <= 1'b1;
		repeat (10) @(posedge MCLK);
		reset <= 1'b0;
	endtask

	// One request per call, back to back when called in a row
	task automatic send(input logic [23:0] byte_addr, input genesis_bus_pkg::bus_data_t wdata,
		input logic rnw, input genesis_bus_pkg::region_e exp_region,
		input genesis_bus_pkg::rom_addr_t exp_rom, input genesis_bus_pkg::bus_data_t exp_rdata);
		genesis_bus_pkg::bus_rsp_t exp;
		exp.region = exp_region;
		exp.rom_addr = exp_rom;
		exp.sram_addr = byte_addr[16:1];
		exp.rdata = exp_rdata;
		@(posedge MCLK);
		req_valid <= 1'b1;
		req.addr <= byte_addr[23:1];
		req.wdata <= wdata;
		req.rnw <= rnw;
		req.be <= 2'b11;
		expect_q.push_back(exp);
	endtask

	// Stop issuing and wait until every response is back
	task automatic finish_requests();
		@(posedge MCLK);
		req_valid <= 1'b0;
		while (expect_q.size() > 0) @(negedge MCLK);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_before = total_errors();
	endtask

	task automatic end_test(input int num);
		int errs;
		errs = total_errors() - errors_before;
		if (errs == 0) begin
			$display("Test %0d %s: passed", num, test_name);
			pass_tests++;
		end else begin
			$display("Test %0d %s: failed with %0d errors", num, test_name, errs);
			fail_tests++;
		end
	endtask

	// ------------------------------------------------------------
	// Response monitor and run limit
	// ------------------------------------------------------------

	always @(negedge MCLK) begin
		if (!reset && rsp_valid) begin
			if (expect_q.size() == 0) begin
				$display("Response arrived in %s with no request pending", test_name);
				error_count++;
			end else begin
				exp_rsp = expect_q.pop_front();
				compare("region", 32'(exp_rsp.region), 32'(rsp.region));
				compare("rdata", 32'(exp_rsp.rdata), 32'(rsp.rdata));
				if (exp_rsp.region == genesis_bus_pkg::ROM) begin
					compare("rom_addr", 32'(exp_rsp.rom_addr), 32'(rsp.rom_addr));
				end
				if (exp_rsp.region == genesis_bus_pkg::SRAM) begin
					compare("sram_addr", 32'(exp_rsp.sram_addr), 32'(rsp.sram_addr));
				end
			end
		end
	end

	always @(posedge MCLK) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------

	initial begin
		logic [23:0] addr;
		logic [31:0] rnd;
		MCLK = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		romsz = 24'h400000;
		z80_busak = 1'b1;
		test_name = "reset";
		void'($urandom(75));
		apply_reset();

		start_test("unbanked_rom");
		for (int i = 0; i < 8; i++) begin
			addr = 24'($urandom) & 24'h7FFFFE;
			send(addr, '0, RD, genesis_bus_pkg::ROM, {1'b0, addr[23:1]}, '0);
		end
		send(24'h800000, '0, RD, genesis_bus_pkg::NONE, '0, '0);
		send(24'h9FFFFE, '0, RD, genesis_bus_pkg::NONE, '0, '0);
		finish_requests();
		end_test(1);

		start_test("sram_enable");
		send(24'h20ABCE, '0, RD, genesis_bus_pkg::ROM, 24'h1055E7, '0);
		send(`GEN_BANKREG_BASE + 24'hF0, 16'h0001, WR, genesis_bus_pkg::BANKREG, '0, '0);
		send(24'h20ABCE, '0, RD, genesis_bus_pkg::SRAM, '0, '0);
		finish_requests();
		end_test(2);

		start_test("bank_registers");
		// SRAM off again so 0x300000 maps to ROM
		send(`GEN_BANKREG_BASE + 24'hF0, 16'h0000, WR, genesis_bus_pkg::BANKREG, '0, '0);
		send(`GEN_BANKREG_BASE + 24'hFC, 16'h001F, WR, genesis_bus_pkg::BANKREG, '0, '0);
		send(24'h300000, '0, RD, genesis_bus_pkg::ROM, {1'b0, 5'h1F, 18'h0}, '0);
		send(24'h080000, '0, RD, genesis_bus_pkg::ROM, {1'b0, 5'd1, 18'h0}, '0);
		finish_requests();
		end_test(3);

		start_test("z80_control");
		send(`GEN_ZBUS_BASE + 24'h100, '0, RD, genesis_bus_pkg::NONE, '0, '0);
		send(`GEN_CTRL_BASE + 24'h100, 16'h0100, WR, genesis_bus_pkg::CTRL, '0, 16'h0100);
		send(`GEN_CTRL_BASE + 24'h200, 16'h0100, WR, genesis_bus_pkg::CTRL, '0, 16'h0000);
		finish_requests();
		compare("z80_busreq", 32'd1, 32'(z80_busreq));
		compare("z80_run", 32'd1, 32'(z80_run));
		@(posedge MCLK);
		z80_busak <= 1'b0;
		send(`GEN_CTRL_BASE + 24'h100, '0, RD, genesis_bus_pkg::CTRL, '0, 16'h0000);
		send(`GEN_CTRL_BASE + 24'h200, '0, RD, genesis_bus_pkg::CTRL, '0, 16'h0100);
		send(`GEN_ZBUS_BASE + 24'h100, '0, RD, genesis_bus_pkg::ZBUS, '0, '0);
		finish_requests();
		end_test(4);

		start_test("system_regions");
		@(posedge MCLK);
		romsz <= 24'h100000;
		z80_busak <= 1'b1;
		apply_reset();
		for (int i = 0; i < 12; i++) begin
			rnd = $urandom;
			if (i % 3 == 0) begin
				addr = `GEN_IO_BASE | (24'(rnd[3:0]) << 1);
				send(addr, '0, RD, genesis_bus_pkg::IO, '0, '0);
			end else if (i % 3 == 1) begin
				// Free bits of a VDP mirror are 20:19, 15:8 and 4:1
				addr = `GEN_VDP_BASE | (24'(rnd[5:4]) << 19) | (24'(rnd[13:6]) << 8)
					| (24'(rnd[17:14]) << 1);
				send(addr, '0, RD, genesis_bus_pkg::VDP, '0, '0);
			end else begin
				addr = `GEN_RAM_BASE | (24'(rnd[20:0]) & 24'h1FFFFE);
				send(addr, '0, RD, genesis_bus_pkg::RAM, '0, '0);
			end
		end
		send(`GEN_BANKREG_BASE + 24'hF2, 16'h001F, WR, genesis_bus_pkg::BANKREG, '0, '0);
		send(24'h080000, '0, RD, genesis_bus_pkg::ROM, 24'h040000, '0);
		send(24'h200000, '0, RD, genesis_bus_pkg::NONE, '0, '0);
		finish_requests();
		end_test(5);

		repeat (4) @(posedge MCLK);
		$display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
			pass_tests, fail_tests, check_count, total_errors());
		if (total_errors() == 0 && fail_tests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+common
common/genesis_bus_pkg.sv
hw/bus/cart_mapper.sv
hw/bus/sys_space_decoder.sv
hw/bus/bus_responder.sv
hw/genesis_bus_top.sv
sim/genesis_bus_asserts.sv
sim/genesis_bus_tb.sv

//--- run.sh
#!/bin/sh
# Build the bus decode testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module genesis_bus_tb \
	-Mdir obj_dir -o genesis_bus_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/genesis_bus_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
